//--- Makefile
SIM  := obj_dir/Vtc_tb
SRCS := $(filter-out +incdir%,$(shell cat vlog.f)) logic/tc_defs.svh

.PHONY: all run clean

all: run

$(SIM): vlog.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module tc_tb -f vlog.f

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf obj_dir

//--- logic/tc_block.sv
`timescale 1ns/1ps
`include "tc_defs.svh"

module tc_block import tc_issue_pkg::*, tc_tile_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       op_valid,
    output logic       op_ready,
    input  tc_uop_t    op,
    output logic       commit_valid,
    input  logic       commit_ready,
    output tc_commit_t commit
);
    localparam int NO = `TC_NUM_OCTETS;
    localparam int LO = `TC_LANE_OFFSET;

    logic [NO-1:0]           oct_ready;
    logic [NO-1:0]           res_valid;
    logic [NO-1:0]           res_ready;
    logic [`TC_NW_WIDTH-1:0] res_wid [NO];
    tc_tile_t                res_d [NO];
    tc_lane_data_t           wb_data_0;
    tc_lane_data_t           wb_data_1;
    tc_meta_t                head_meta;
    logic                    meta_full;
    logic                    ops_valid;
    logic                    op_fire;
    logic                    commit_fire;
    // commit is serialized per warp, so one beat bit covers every warp
    logic                    subcommit;

    // octets and metadata queue accept together or not at all
    assign ops_valid = op_valid && !meta_full;
    assign op_ready  = (&oct_ready) && !meta_full;
    assign op_fire   = op_valid && op_ready;

    for (genvar i = 0; i < NO; i++) begin : g_octet
        tc_octet_ops_t ops;

        // words 0-3 from thread group 0, words 4-7 from thread group 1
        assign ops.a            = {op.rs1[LO + 4*i +: 4], op.rs1[4*i +: 4]};
        assign ops.b            = {op.rs2[LO + 4*i +: 4], op.rs2[4*i +: 4]};
        assign ops.c            = {op.rs3[LO + 4*i +: 4], op.rs3[4*i +: 4]};
        assign ops.step         = op.step;
        assign ops.last_in_pair = op.last_in_pair;
        assign ops.wid          = op.meta.wid;

        tc_octet i_octet (
            .clk          (clk),
            .reset        (reset),
            .ops_valid    (ops_valid),
            .ops          (ops),
            .ops_ready    (oct_ready[i]),
            .result_valid (res_valid[i]),
            .result_ready (res_ready[i]),
            .d            (res_d[i]),
            .d_wid        (res_wid[i])
        );
    end

    // 8 lanes per octet write a 4x4 tile, so beat 0 takes columns 0 and 2
    // and beat 1 takes columns 1 and 3
    always_comb begin
        for (int i = 0; i < NO; i++) begin
            for (int t = 0; t < 2; t++) begin
                wb_data_0[LO*t + 4*i + 0] = res_d[i][2*t][0];
                wb_data_0[LO*t + 4*i + 1] = res_d[i][2*t+1][0];
                wb_data_0[LO*t + 4*i + 2] = res_d[i][2*t][2];
                wb_data_0[LO*t + 4*i + 3] = res_d[i][2*t+1][2];
                wb_data_1[LO*t + 4*i + 0] = res_d[i][2*t][1];
                wb_data_1[LO*t + 4*i + 1] = res_d[i][2*t+1][1];
                wb_data_1[LO*t + 4*i + 2] = res_d[i][2*t][3];
                wb_data_1[LO*t + 4*i + 3] = res_d[i][2*t+1][3];
            end
        end
    end

    tc_uop_queue i_uop_queue (
        .clk       (clk),
        .reset     (reset),
        .push      (op_fire),
        .push_meta (op.meta),
        .pop       (commit_fire),
        .pop_wid   (res_wid[0]),
        .head_meta (head_meta),
        .full      (meta_full)
    );

    assign commit_valid = &res_valid;
    assign commit_fire  = commit_valid && commit_ready;
    assign commit.meta  = head_meta;
    assign commit.data  = subcommit ? wb_data_1 : wb_data_0;
    // tiles leave the result buffers only after their second beat
    assign res_ready    = {NO{commit_fire && subcommit}};

    always_ff @(posedge clk) begin
        if (reset) begin
            subcommit <= 1'b0;
        end else if (commit_fire) begin
            subcommit <= ~subcommit;
        end
    end

endmodule

//--- logic/tc_defs.svh
`ifndef TC_DEFS_SVH
`define TC_DEFS_SVH

// lane and warp geometry
`define TC_NUM_THREADS  16
`define TC_NUM_WARPS    4
`define TC_NW_WIDTH     2
`define TC_NUM_OCTETS   (`TC_NUM_THREADS / 8)
// lanes of the second thread group of an octet start this far up
`define TC_LANE_OFFSET  (4 * `TC_NUM_OCTETS)

// datapath and commit field widths
`define TC_XLEN         32
`define TC_NR_BITS      5
`define TC_UUID_WIDTH   16

// pipeline and buffer depths
`define TC_HMMA_LATENCY 3
// rule of thumb, enough uops to cover the dpu in flight
`define TC_META_DEPTH   (2 * `TC_HMMA_LATENCY)
`define TC_RESULT_DEPTH 2

`endif

//--- logic/tc_dpu.sv
`timescale 1ns/1ps
`include "tc_defs.svh"

module tc_dpu import tc_tile_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  tc_a_tile_t              a,
    input  tc_b_tile_t              b,
    input  tc_tile_t                c,
    input  logic [`TC_NW_WIDTH-1:0] in_wid,
    output logic                    out_valid,
    input  logic                    out_ready,
    output tc_tile_t                d,
    output logic [`TC_NW_WIDTH-1:0] out_wid
);
    localparam int LAT = `TC_HMMA_LATENCY;

    logic [LAT-1:0]          s_valid;
    logic [`TC_NW_WIDTH-1:0] s_wid [LAT];
    tc_tile_t                s_d [LAT];
    // k = 1 operands carried into the second stage
    tc_half_t                s_a1;
    tc_half_t                s_b1;
    logic                    advance;

    // the whole pipe moves together, a stall freezes every stage
    assign advance  = !s_valid[LAT-1] || out_ready;
    assign in_ready = advance;

    always_ff @(posedge clk) begin
        if (reset) begin
            s_valid <= '0;
        end else if (advance) begin
            s_valid <= {s_valid[LAT-2:0], in_valid};
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            // first stage, c plus the k = 0 products
            for (int r = 0; r < 4; r++) begin
                for (int j = 0; j < 4; j++) begin
                    s_d[0][r][j] <= c[r][j] + a[r][0] * b[0][j];
                end
                s_a1[r] <= a[r][1];
                s_b1[r] <= b[1][r];
            end
            s_wid[0] <= in_wid;
            // second stage adds the k = 1 products
            for (int r = 0; r < 4; r++) begin
                for (int j = 0; j < 4; j++) begin
                    s_d[1][r][j] <= s_d[0][r][j] + s_a1[r] * s_b1[j];
                end
            end
            s_wid[1] <= s_wid[0];
            // remaining stages only carry the result
            for (int k = 2; k < LAT; k++) begin
                s_d[k]   <= s_d[k-1];
                s_wid[k] <= s_wid[k-1];
            end
        end
    end

    assign out_valid = s_valid[LAT-1];
    assign d         = s_d[LAT-1];
    assign out_wid   = s_wid[LAT-1];

    // a stalled result must be held until it is taken
    assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(d) && $stable(out_wid));

endmodule

//--- logic/tc_issue_pkg.sv
`include "tc_defs.svh"

package tc_issue_pkg;

    // commit fields kept per uop until its writeback beat
    typedef struct packed {
        logic [`TC_UUID_WIDTH-1:0]  uuid;
        logic [`TC_NW_WIDTH-1:0]    wid;
        logic [`TC_NUM_THREADS-1:0] tmask;
        logic [`TC_XLEN-1:0]        pc;
        logic                       wb;
        logic [`TC_NR_BITS-1:0]     rd;
    } tc_meta_t;

    // one word per lane
    typedef logic [`TC_NUM_THREADS-1:0][`TC_XLEN-1:0] tc_lane_data_t;

    // one uop on the operand port
    typedef struct packed {
        tc_meta_t      meta;
        // selects which A and B halves this uop supplies
        logic [1:0]    step;
        // second uop of the pair, starts the hmma
        logic          last_in_pair;
        tc_lane_data_t rs1;
        tc_lane_data_t rs2;
        tc_lane_data_t rs3;
    } tc_uop_t;

    // one writeback beat on the commit port
    typedef struct packed {
        tc_meta_t      meta;
        tc_lane_data_t data;
    } tc_commit_t;

endpackage

//--- logic/tc_octet.sv
`timescale 1ns/1ps
`include "tc_defs.svh"

module tc_octet import tc_tile_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    ops_valid,
    input  tc_octet_ops_t           ops,
    output logic                    ops_ready,
    output logic                    result_valid,
    input  logic                    result_ready,
    output tc_tile_t                d,
    output logic [`TC_NW_WIDTH-1:0] d_wid
);
    localparam int DEPTH = `TC_RESULT_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    typedef struct packed {
        tc_half_t        a;
        tc_half_t        b;
        tc_octet_words_t c;
    } half_set_t;

    function automatic half_set_t select_half(input tc_octet_ops_t o);
        half_set_t h;
        // A rows 0-1 come from thread group 0, rows 2-3 from thread group 1
        if (o.step[0]) begin
            h.a = {o.a[7:6], o.a[3:2]};
        end else begin
            h.a = {o.a[5:4], o.a[1:0]};
        end
        // B half is shared by both thread groups
        h.b = o.step[1] ? o.b[7:4] : o.b[3:0];
        h.c = o.c;
        return h;
    endfunction

    // first-in-pair halves, one slot per warp
    tc_half_t                a_buf [`TC_NUM_WARPS];
    tc_half_t                b_buf [`TC_NUM_WARPS];
    tc_octet_words_t         c_buf [`TC_NUM_WARPS];
    half_set_t               cur;
    logic                    first_fire;
    tc_a_tile_t              a_tile;
    tc_b_tile_t              b_tile;
    tc_tile_t                c_tile;
    logic                    dpu_ready;
    logic                    dpu_out_valid;
    logic                    dpu_out_ready;
    tc_tile_t                dpu_d;
    logic [`TC_NW_WIDTH-1:0] dpu_wid;
    tc_tile_t                rb_d [DEPTH];
    logic [`TC_NW_WIDTH-1:0] rb_wid [DEPTH];
    logic [PTR_W-1:0]        rb_wr;
    logic [PTR_W-1:0]        rb_rd;
    logic [PTR_W:0]          rb_count;
    logic                    rb_full;
    logic                    rb_push;
    logic                    rb_pop;

    assign cur = select_half(ops);
    // a first half only needs its staging slot, a second half needs the dpu
    assign ops_ready  = dpu_ready || !ops.last_in_pair;
    assign first_fire = ops_valid && ops_ready && !ops.last_in_pair;

    always_ff @(posedge clk) begin
        if (first_fire) begin
            a_buf[ops.wid] <= cur.a;
            b_buf[ops.wid] <= cur.b;
            c_buf[ops.wid] <= cur.c;
        end
    end

    always_comb begin
        int base;
        for (int r = 0; r < 4; r++) begin
            a_tile[r][0] = a_buf[ops.wid][r];
            a_tile[r][1] = cur.a[r];
            // C rows 0-1 use words 0-3, rows 2-3 use words 4-7
            base = (r < 2) ? r : r + 2;
            c_tile[r][0] = c_buf[ops.wid][base];
            c_tile[r][1] = cur.c[base];
            c_tile[r][2] = c_buf[ops.wid][base + 2];
            c_tile[r][3] = cur.c[base + 2];
        end
        b_tile[0] = b_buf[ops.wid];
        b_tile[1] = cur.b;
    end

    tc_dpu i_dpu (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (ops_valid && ops.last_in_pair),
        .in_ready  (dpu_ready),
        .a         (a_tile),
        .b         (b_tile),
        .c         (c_tile),
        .in_wid    (ops.wid),
        .out_valid (dpu_out_valid),
        .out_ready (dpu_out_ready),
        .d         (dpu_d),
        .out_wid   (dpu_wid)
    );

    // result buffer holds a tile across its two commit beats
    assign rb_full       = (rb_count == (PTR_W+1)'(DEPTH));
    assign dpu_out_ready = !rb_full;
    assign rb_push       = dpu_out_valid && dpu_out_ready;
    assign result_valid  = (rb_count != '0);
    assign rb_pop        = result_valid && result_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            rb_wr    <= '0;
            rb_rd    <= '0;
            rb_count <= '0;
        end else begin
            if (rb_push) begin
                rb_wr <= (rb_wr == PTR_W'(DEPTH - 1)) ? '0 : rb_wr + 1'b1;
            end
            if (rb_pop) begin
                rb_rd <= (rb_rd == PTR_W'(DEPTH - 1)) ? '0 : rb_rd + 1'b1;
            end
            if (rb_push && !rb_pop) begin
                rb_count <= rb_count + 1'b1;
            end else if (rb_pop && !rb_push) begin
                rb_count <= rb_count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rb_push) begin
            rb_d[rb_wr]   <= dpu_d;
            rb_wid[rb_wr] <= dpu_wid;
        end
    end

    assign d     = rb_d[rb_rd];
    assign d_wid = rb_wid[rb_rd];

    // the buffer never holds more tiles than it has slots
    assert property (@(posedge clk) disable iff (reset)
        rb_count <= (PTR_W+1)'(DEPTH));

endmodule

//--- logic/tc_tile_pkg.sv
`include "tc_defs.svh"

package tc_tile_pkg;

    typedef logic [`TC_XLEN-1:0] tc_word_t;

    // eight words gathered by an octet, two thread groups of four lanes
    typedef tc_word_t [7:0] tc_octet_words_t;
    // half of an A or B tile
    typedef tc_word_t [3:0] tc_half_t;

    // operands of one uop as seen by one octet
    typedef struct packed {
        tc_octet_words_t         a;
        tc_octet_words_t         b;
        tc_octet_words_t         c;
        logic [1:0]              step;
        logic                    last_in_pair;
        logic [`TC_NW_WIDTH-1:0] wid;
    } tc_octet_ops_t;

    typedef tc_word_t [3:0][1:0] tc_a_tile_t;
    typedef tc_word_t [1:0][3:0] tc_b_tile_t;
    typedef tc_word_t [3:0][3:0] tc_tile_t;

endpackage

//--- logic/tc_uop_queue.sv
`timescale 1ns/1ps
`include "tc_defs.svh"

module tc_uop_queue import tc_issue_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    push,
    input  tc_meta_t                push_meta,
    input  logic                    pop,
    input  logic [`TC_NW_WIDTH-1:0] pop_wid,
    output tc_meta_t                head_meta,
    output logic                    full
);
    localparam int DEPTH = `TC_META_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    tc_meta_t                 mem [`TC_NUM_WARPS][DEPTH];
    logic [PTR_W-1:0]         wr_ptr [`TC_NUM_WARPS];
    logic [PTR_W-1:0]         rd_ptr [`TC_NUM_WARPS];
    logic [CNT_W-1:0]         count [`TC_NUM_WARPS];
    logic [`TC_NUM_WARPS-1:0] full_w;
    logic [`TC_NUM_WARPS-1:0] empty_w;

    // separate FIFOs keep the two beats of a warp's pair adjacent at its head
    for (genvar w = 0; w < `TC_NUM_WARPS; w++) begin : g_warp
        logic do_push;
        logic do_pop;

        assign do_push    = push && (push_meta.wid == `TC_NW_WIDTH'(w));
        assign do_pop     = pop && (pop_wid == `TC_NW_WIDTH'(w));
        assign full_w[w]  = (count[w] == CNT_W'(DEPTH));
        assign empty_w[w] = (count[w] == '0);

        always_ff @(posedge clk) begin
            if (reset) begin
                wr_ptr[w] <= '0;
                rd_ptr[w] <= '0;
                count[w]  <= '0;
            end else begin
                if (do_push) begin
                    wr_ptr[w] <= (wr_ptr[w] == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr[w] + 1'b1;
                end
                if (do_pop) begin
                    rd_ptr[w] <= (rd_ptr[w] == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr[w] + 1'b1;
                end
                if (do_push && !do_pop) begin
                    count[w] <= count[w] + 1'b1;
                end else if (do_pop && !do_push) begin
                    count[w] <= count[w] - 1'b1;
                end
            end
        end

        always_ff @(posedge clk) begin
            if (do_push) begin
                mem[w][wr_ptr[w]] <= push_meta;
            end
        end
    end

    assign head_meta = mem[pop_wid][rd_ptr[pop_wid]];
    // any full warp blocks issue for all warps
    assign full      = |full_w;

    assert property (@(posedge clk) disable iff (reset) push |-> !full_w[push_meta.wid]);
    assert property (@(posedge clk) disable iff (reset) pop |-> !empty_w[pop_wid]);

endmodule

//--- verif/tc_tb.sv
`timescale 1ns/1ps
`include "tc_defs.svh"

module tc_tb import tc_issue_pkg::*; ();
    localparam int NT          = `TC_NUM_THREADS;
    localparam int NO          = `TC_NUM_OCTETS;
    localparam int NW          = `TC_NUM_WARPS;
    localparam int LO          = `TC_LANE_OFFSET;
    localparam int MIX_UOPS    = 32;
    localparam int TOTAL_UOPS  = 8 + 3 * MIX_UOPS;
    localparam int CYCLE_LIMIT = 4 * TOTAL_UOPS * (`TC_HMMA_LATENCY + 4) + 200;

    typedef tc_commit_t [1:0] beat_pair_t;

    logic       clk;
    logic       reset;
    logic       op_valid;
    logic       op_ready;
    tc_uop_t    op;
    logic       commit_valid;
    logic       commit_ready;
    tc_commit_t commit;

    logic [31:0]               lcg_state;
    logic [`TC_UUID_WIDTH-1:0] next_uuid;
    // 0 always ready, 1 random, 2 held low
    int                        ready_mode;
    int                        errors;
    int                        checks;
    int                        accepted;
    int                        pairs;
    int                        beats;
    int                        cycles;
    int                        test_err_base;
    tc_commit_t                exp_q [$];
    tc_uop_t                   first_of [NW];

    tc_block i_tc_block (
        .clk          (clk),
        .reset        (reset),
        .op_valid     (op_valid),
        .op_ready     (op_ready),
        .op           (op),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit       (commit)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // expected commit beats of one pair, built from the lane and tile rules
    function automatic beat_pair_t tc_expect(input tc_uop_t first, input tc_uop_t second);
        beat_pair_t  res;
        tc_uop_t     u;
        logic [31:0] wa [2][8];
        logic [31:0] wb [2][8];
        logic [31:0] wc [2][8];
        logic [31:0] ah [2][4];
        logic [31:0] bh [2][4];
        logic [31:0] dt [4][4];
        int          lane;
        int          sel;
        int          row;
        int          col;
        res[0].meta = first.meta;
        res[1].meta = second.meta;
        for (int i = 0; i < NO; i++) begin
            for (int k = 0; k < 2; k++) begin
                u = (k == 0) ? first : second;
                for (int w = 0; w < 8; w++) begin
                    lane     = (w < 4) ? 4 * i + w : LO + 4 * i + w - 4;
                    wa[k][w] = u.rs1[lane];
                    wb[k][w] = u.rs2[lane];
                    wc[k][w] = u.rs3[lane];
                end
                // odd steps take the upper A pair of each thread group
                sel      = u.step[0] ? 2 : 0;
                ah[k][0] = wa[k][sel];
                ah[k][1] = wa[k][sel + 1];
                ah[k][2] = wa[k][sel + 4];
                ah[k][3] = wa[k][sel + 5];
                sel      = u.step[1] ? 4 : 0;
                for (int j = 0; j < 4; j++) begin
                    bh[k][j] = wb[k][sel + j];
                end
            end
            for (int r = 0; r < 4; r++) begin
                for (int j = 0; j < 4; j++) begin
                    // even columns of C from the first uop, odd from the second
                    sel      = ((r < 2) ? r : r + 2) + 2 * (j / 2);
                    dt[r][j] = wc[j % 2][sel] + ah[0][r] * bh[0][j] + ah[1][r] * bh[1][j];
                end
            end
            for (int g = 0; g < 2; g++) begin
                for (int p = 0; p < 4; p++) begin
                    lane = LO * g + 4 * i + p;
                    row  = 2 * g + p % 2;
                    col  = 2 * (p / 2);
                    res[0].data[lane] = dt[row][col];
                    res[1].data[lane] = dt[row][col + 1];
                end
            end
        end
        return res;
    endfunction

    function automatic tc_uop_t make_uop(input logic [1:0] wid, input logic [1:0] step,
                                         input logic last);
        tc_uop_t     u;
        logic [31:0] r;
        r              = next_random();
        u.meta.uuid    = next_uuid;
        next_uuid      = next_uuid + 1'b1;
        u.meta.wid     = wid;
        u.meta.tmask   = r[`TC_NUM_THREADS-1:0];
        u.meta.wb      = r[31];
        u.meta.rd      = r[20 +: `TC_NR_BITS];
        u.meta.pc      = next_random();
        u.step         = step;
        u.last_in_pair = last;
        for (int l = 0; l < NT; l++) begin
            u.rs1[l] = next_random();
            u.rs2[l] = next_random();
            u.rs3[l] = next_random();
        end
        return u;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, want);
            errors++;
        end
    endtask

    task automatic check_beat(input tc_commit_t got, input tc_commit_t want);
        check_field("commit.meta.uuid", 32'(got.meta.uuid), 32'(want.meta.uuid));
        check_field("commit.meta.wid", 32'(got.meta.wid), 32'(want.meta.wid));
        check_field("commit.meta.tmask", 32'(got.meta.tmask), 32'(want.meta.tmask));
        check_field("commit.meta.pc", got.meta.pc, want.meta.pc);
        check_field("commit.meta.wb", 32'(got.meta.wb), 32'(want.meta.wb));
        check_field("commit.meta.rd", 32'(got.meta.rd), 32'(want.meta.rd));
        for (int l = 0; l < NT; l++) begin
            check_field($sformatf("commit.data[%0d]", l), got.data[l], want.data[l]);
        end
    endtask

    // called 10 ns after a rising edge, returns at the same point after the fire
    task automatic send_uop(input tc_uop_t u);
        beat_pair_t exp_beats;
        logic       fired;
        fired    = 1'b0;
        op       = u;
        op_valid = 1'b1;
        while (!fired) begin
            @(negedge clk);
            fired = op_ready;
            @(posedge clk);
            #10;
        end
        op_valid = 1'b0;
        accepted++;
        if (u.last_in_pair) begin
            exp_beats = tc_expect(first_of[u.meta.wid], u);
            exp_q.push_back(exp_beats[0]);
            exp_q.push_back(exp_beats[1]);
            pairs++;
        end else begin
            first_of[u.meta.wid] = u;
        end
    endtask

    // alternating rounds of interleaved and back-to-back pairs over all warps
    task automatic run_mix();
        logic [1:0]  steps [NW];
        logic [31:0] r;
        for (int round = 0; round < MIX_UOPS / (2 * NW); round++) begin
            for (int w = 0; w < NW; w++) begin
                r        = next_random();
                steps[w] = r[9:8];
            end
            if (round % 2 == 0) begin
                for (int w = 0; w < NW; w++) begin
                    send_uop(make_uop(2'(w), steps[w], 1'b0));
                end
                for (int w = 0; w < NW; w++) begin
                    send_uop(make_uop(2'(w), steps[w], 1'b1));
                end
            end else begin
                for (int w = 0; w < NW; w++) begin
                    send_uop(make_uop(2'(w), steps[w], 1'b0));
                    send_uop(make_uop(2'(w), steps[w], 1'b1));
                end
            end
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        // a duplicated beat would show up in these cycles
        repeat (4) @(posedge clk);
        #10;
        checks++;
        assert (beats == 2 * pairs) else begin
            $display("%0t: saw %0d commit beats for %0d issued pairs", $time, beats, pairs);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %s finished, %0d errors", name, errors - test_err_base);
        test_err_base = errors;
    endtask

    always @(posedge clk) begin : drive_ready
        logic [31:0] r;
        r = next_random();
        #10;
        if (ready_mode == 1) begin
            commit_ready = r[17];
        end else begin
            commit_ready = (ready_mode == 0);
        end
    end

    always @(negedge clk) begin : compare
        tc_commit_t want;
        if (!reset && commit_valid && commit_ready) begin
            beats++;
            checks++;
            assert (exp_q.size() != 0) else begin
                $display("%0t: commit beat arrived with no expected beat pending", $time);
                errors++;
            end
            if (exp_q.size() != 0) begin
                want = exp_q.pop_front();
                check_beat(commit, want);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles with %0d beats pending", cycles, exp_q.size());
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        int hold_uops;
        int hold_pairs;
        clk           = 1'b0;
        reset         = 1'b1;
        op_valid      = 1'b0;
        op            = '0;
        commit_ready  = 1'b1;
        ready_mode    = 0;
        lcg_state     = 32'h74ca;
        next_uuid     = '0;
        errors        = 0;
        checks        = 0;
        accepted      = 0;
        pairs         = 0;
        beats         = 0;
        cycles        = 0;
        test_err_base = 0;
        repeat (5) @(posedge clk);
        #10;
        reset = 1'b0;

        @(negedge clk);
        check_field("commit_valid", 32'(commit_valid), 32'd0);
        check_field("op_ready", 32'(op_ready), 32'd1);
        @(posedge clk);
        #10;
        finish_test("reset state");

        for (int s = 0; s < 4; s++) begin
            send_uop(make_uop(2'd1, 2'(s), 1'b0));
            send_uop(make_uop(2'd1, 2'(s), 1'b1));
        end
        wait_drain();
        finish_test("single warp steps");

        run_mix();
        wait_drain();
        finish_test("interleaved warps");

        ready_mode = 1;
        run_mix();
        wait_drain();
        ready_mode = 0;
        finish_test("random commit_ready");

        // the DUT is idle here, so everything accepted below stays inside it
        ready_mode   = 2;
        commit_ready = 1'b0;
        hold_uops    = accepted;
        hold_pairs   = pairs;
        fork
            run_mix();
            begin
                repeat (40) @(posedge clk);
                @(negedge clk);
                checks++;
                assert (op_valid && !op_ready) else begin
                    $display("%0t: op_ready stayed high under commit back-pressure", $time);
                    errors++;
                end
                checks++;
                assert (pairs - hold_pairs <= `TC_HMMA_LATENCY + `TC_RESULT_DEPTH) else begin
                    $display("%0t: %0d pairs accepted while commits were blocked",
                             $time, pairs - hold_pairs);
                    errors++;
                end
                checks++;
                assert (accepted - hold_uops <= NW * `TC_META_DEPTH) else begin
                    $display("%0t: %0d uops accepted while commits were blocked",
                             $time, accepted - hold_uops);
                    errors++;
                end
                ready_mode = 0;
            end
        join
        wait_drain();
        finish_test("commit back-pressure");

        $display("checks %0d, errors %0d, uops %0d, pairs %0d, commit beats %0d",
                 checks, errors, accepted, pairs, beats);
        if (errors == 0 && exp_q.size() == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+logic
logic/tc_issue_pkg.sv
logic/tc_tile_pkg.sv
logic/tc_dpu.sv
logic/tc_octet.sv
logic/tc_uop_queue.sv
logic/tc_block.sv
verif/tc_tb.sv
